// File: sim.f
common/daq_pkg.sv
common/chan_cmd_if.sv
design/sync_fifo.sv
ebi/ebi.sv
design/cmd_dispatcher.sv
design/sample_channel.sv
design/sample_merger.sv
design/daq_top.sv
testbench/tb_daq_top.sv

// File: Bender.yml
package:
  name: daq_bridge

sources:
  - common/daq_pkg.sv
  - common/chan_cmd_if.sv
  - design/sync_fifo.sv
  - ebi/ebi.sv
  - design/cmd_dispatcher.sv
  - design/sample_channel.sv
  - design/sample_merger.sv
  - design/daq_top.sv
  - target: test
    files:
      - testbench/tb_daq_top.sv

// File: testbench/tb_daq_top.sv
`timescale 1ns/1ps

module tb_daq_top import daq_pkg::*; ();

	localparam int NUM_CHAN = 4;
	// Whole run needs a few thousand cycles, so this leaves a wide margin
	localparam int MAX_CYCLES = 20000;

	localparam word_t M_CMD_FULL  = word_t'(1) << STAT_CMD_FULL;
	localparam word_t M_CMD_EMPTY = word_t'(1) << STAT_CMD_EMPTY;
	localparam word_t M_SMP_EMPTY = word_t'(1) << STAT_SMP_EMPTY;
	localparam word_t M_SMP_FULL  = word_t'(1) << STAT_SMP_FULL;

	logic      clk = 1'b0;
	logic      rst;
	word_t     data_in;
	word_t     data_out;
	ebi_addr_t addr;
	logic      rd;
	logic      wr;
	logic      cs;

	int          errors = 0;
	int          checks = 0;
	int          cycles = 0;

	// Reference model per channel
	value_t base_m [NUM_CHAN];
	value_t step_m [NUM_CHAN];
	value_t exp_q  [NUM_CHAN][$];

	daq_top dut_i (
		.clk      (clk),
		.rst      (rst),
		.data_in  (data_in),
		.data_out (data_out),
		.addr     (addr),
		.rd       (rd),
		.wr       (wr),
		.cs       (cs)
	);

	always #20 clk = ~clk;

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= MAX_CYCLES) begin
			$display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
			$display("=== FAIL ===");
			$finish;
		end
	end

	task check_eq(input string name, input logic [15:0] expected, input logic [15:0] actual);
		checks++;
		if (expected !== actual) begin
			errors++;
			$display("MISMATCH %s: expected %h, actual %h", name, expected, actual);
		end
	endtask

	// Strobe high for two cycles, low for two
	task bus_write(input ebi_addr_t a, input word_t d);
		@(posedge clk);
		cs      <= 1'b1;
		wr      <= 1'b1;
		addr    <= a;
		data_in <= d;
		repeat (2) @(posedge clk);
		cs <= 1'b0;
		wr <= 1'b0;
		@(posedge clk);
	endtask

	task bus_read(input ebi_addr_t a, output word_t d);
		@(posedge clk);
		cs   <= 1'b1;
		rd   <= 1'b1;
		addr <= a;
		@(negedge clk);
		d = data_out;
		repeat (2) @(posedge clk);
		cs <= 1'b0;
		rd <= 1'b0;
		@(posedge clk);
	endtask

	task wait_status(input word_t mask, input word_t want);
		word_t s;
		bus_read(ADDR_STATUS, s);
		while ((s & mask) != want) begin
			bus_read(ADDR_STATUS, s);
		end
	endtask

	// Also advances the model for channels that exist
	task send_cmd(input opcode_t op, input chan_id_t ch, input word_t operand);
		wait_status(M_CMD_FULL, '0);
		bus_write(ADDR_CMD_W1, {op, ch});
		bus_write(ADDR_CMD_W2, '0);
		bus_write(ADDR_CMD_W3, '0);
		bus_write(ADDR_CMD_W4, operand);
		if (ch < NUM_CHAN) begin
			case (op)
				OP_SET_BASE: base_m[ch] = operand[11:0];
				OP_SET_STEP: step_m[ch] = operand[11:0];
				OP_EMIT: begin
					for (int k = 0; k < int'(operand); k++) begin
						exp_q[ch].push_back(base_m[ch]);
						base_m[ch] = base_m[ch] + step_m[ch];
					end
				end
				default: ;
			endcase
		end
	endtask

	task read_sample(output sample_t s);
		wait_status(M_SMP_EMPTY, '0);
		bus_read(ADDR_SAMPLE, s);
	endtask

	// Match against the queue named by the sample's channel field
	task check_sample(input string name, input sample_t s);
		int     ch;
		value_t exp_v;
		ch = int'(s[15:12]);
		if (ch >= NUM_CHAN) begin
			errors++;
			$display("%s: sample %h names channel %0d, which does not exist", name, s, ch);
		end else if (exp_q[ch].size() == 0) begin
			errors++;
			$display("%s: sample %h from channel %0d was not expected", name, s, ch);
		end else begin
			exp_v = exp_q[ch].pop_front();
			check_eq(name, {4'(ch), exp_v}, s);
		end
	endtask

	task drain_and_check(input string name, input int n);
		sample_t s;
		for (int i = 0; i < n; i++) begin
			read_sample(s);
			check_sample(name, s);
		end
	endtask

	task check_model_empty(input string name);
		for (int c = 0; c < NUM_CHAN; c++) begin
			if (exp_q[c].size() != 0) begin
				errors++;
				$display("%s: %0d samples of channel %0d never arrived",
					name, exp_q[c].size(), c);
			end
		end
	endtask

	task test_reset_state();
		word_t s;
		bus_read(ADDR_STATUS, s);
		check_eq("reset_status", M_CMD_EMPTY | M_SMP_EMPTY, s);
		bus_read(ADDR_SAMPLE, s);
		check_eq("reset_sample", '0, s);
	endtask

	task test_single_run();
		send_cmd(OP_SET_BASE, 8'd1, 16'h0ffd);
		send_cmd(OP_SET_STEP, 8'd1, 16'h0002);
		send_cmd(OP_EMIT, 8'd1, 16'd5);
		// Command FIFO empty with samples waiting
		wait_status(M_CMD_EMPTY | M_SMP_EMPTY, M_CMD_EMPTY);
		drain_and_check("single_run", 5);
	endtask

	task test_continue_run();
		send_cmd(OP_EMIT, 8'd1, 16'd3);
		drain_and_check("continue_run", 3);
		check_model_empty("continue_run");
	endtask

	task test_all_channels();
		for (int c = 0; c < NUM_CHAN; c++) begin
			send_cmd(OP_SET_BASE, chan_id_t'(c), word_t'(value_t'($urandom())));
			send_cmd(OP_SET_STEP, chan_id_t'(c), word_t'(value_t'($urandom())));
			send_cmd(OP_EMIT, chan_id_t'(c), 16'd5);
		end
		drain_and_check("all_channels", 5 * NUM_CHAN);
		check_model_empty("all_channels");
	endtask

	task test_bad_channel();
		word_t s;
		send_cmd(OP_EMIT, 8'd7, 16'd3);
		send_cmd(OP_SET_BASE, 8'd200, 16'h0123);
		wait_status(M_CMD_EMPTY, M_CMD_EMPTY);
		bus_read(ADDR_STATUS, s);
		check_eq("bad_count", 16'd2, 16'(s[STAT_BAD_LSB +: 8]));
		check_eq("bad_no_samples", 16'd1, 16'(s[STAT_SMP_EMPTY]));
	endtask

	task test_back_pressure();
		word_t s;
		send_cmd(OP_SET_BASE, 8'd2, word_t'(value_t'($urandom())));
		send_cmd(OP_SET_STEP, 8'd2, word_t'(value_t'($urandom())));
		send_cmd(OP_EMIT, 8'd2, 16'd40);
		wait_status(M_SMP_FULL, M_SMP_FULL);
		bus_read(ADDR_STATUS, s);
		// Sample FIFO full, command FIFO drained, earlier bad count kept
		check_eq("bp_full", M_CMD_EMPTY | M_SMP_FULL | (word_t'(2) << STAT_BAD_LSB), s);
		drain_and_check("bp_drain", 40);
		check_model_empty("bp_drain");
		bus_read(ADDR_STATUS, s);
		check_eq("bp_end_empty", 16'd1, 16'(s[STAT_SMP_EMPTY]));
		// Nothing repeated after the run
		bus_read(ADDR_SAMPLE, s);
		check_eq("bp_no_extra", '0, s);
	endtask

	initial begin
		void'($urandom(32'h29227b9c));
		rst     <= 1'b1;
		data_in <= '0;
		addr    <= '0;
		rd      <= 1'b0;
		wr      <= 1'b0;
		cs      <= 1'b0;
		for (int c = 0; c < NUM_CHAN; c++) begin
			base_m[c] = '0;
			step_m[c] = '0;
		end
		repeat (3) @(posedge clk);
		rst <= 1'b0;
		repeat (2) @(posedge clk);

		test_reset_state();
		test_single_run();
		test_continue_run();
		test_all_channels();
		test_bad_channel();
		test_back_pressure();

		$display("Checks: %0d, errors: %0d, cycles: %0d", checks, errors, cycles);
		if (errors == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule

// File: design/daq_top.sv
`timescale 1ns/1ps

module daq_top import daq_pkg::*; #(
	parameter int N_CHAN    = 4,
	parameter int CMD_DEPTH = 4,
	parameter int SMP_DEPTH = 16
) (
	input  logic      clk,
	input  logic      rst,
	input  word_t     data_in,
	output word_t     data_out,
	input  ebi_addr_t addr,
	input  logic      rd,
	input  logic      wr,
	input  logic      cs
);

	cmd_t              cmd_in;
	cmd_t              cmd_head;
	logic              cmd_wr_en;
	logic              cmd_rd_en;
	logic              cmd_full;
	logic              cmd_empty;
	sample_t           smp_head;
	sample_t           smp_in;
	logic              smp_wr_en;
	logic              smp_rd_en;
	logic              smp_full;
	logic              smp_empty;
	logic [7:0]        bad_cmd_count;
	logic [N_CHAN-1:0] ch_req;
	logic [N_CHAN-1:0] ch_ack;
	sample_t           ch_data [N_CHAN];

	chan_cmd_if chan_bus [N_CHAN] ();

	ebi ebi_i (
		.clk           (clk),
		.rst           (rst),
		.data_in       (data_in),
		.data_out      (data_out),
		.addr          (addr),
		.rd            (rd),
		.wr            (wr),
		.cs            (cs),
		.cmd_data      (cmd_in),
		.cmd_wr_en     (cmd_wr_en),
		.cmd_full      (cmd_full),
		.cmd_empty     (cmd_empty),
		.smp_data      (smp_head),
		.smp_rd_en     (smp_rd_en),
		.smp_empty     (smp_empty),
		.smp_full      (smp_full),
		.bad_cmd_count (bad_cmd_count)
	);

	sync_fifo #(.WIDTH($bits(cmd_t)), .DEPTH(CMD_DEPTH)) cmd_fifo_i (
		.clk     (clk),
		.rst     (rst),
		.wr_en   (cmd_wr_en),
		.wr_data (cmd_in),
		.rd_en   (cmd_rd_en),
		.rd_data (cmd_head),
		.full    (cmd_full),
		.empty   (cmd_empty)
	);

	cmd_dispatcher #(.N_CHAN(N_CHAN)) dispatcher_i (
		.clk           (clk),
		.rst           (rst),
		.cmd_data      (cmd_head),
		.cmd_empty     (cmd_empty),
		.cmd_rd_en     (cmd_rd_en),
		.chan          (chan_bus),
		.bad_cmd_count (bad_cmd_count)
	);

	for (genvar i = 0; i < N_CHAN; i++) begin : g_chan
		sample_channel #(.CHAN_ID(i)) chan_i (
			.clk      (clk),
			.rst      (rst),
			.cmd      (chan_bus[i]),
			.smp_req  (ch_req[i]),
			.smp_ack  (ch_ack[i]),
			.smp_data (ch_data[i])
		);
	end

	sample_merger #(.N_CHAN(N_CHAN)) merger_i (
		.clk        (clk),
		.rst        (rst),
		.smp_req    (ch_req),
		.smp_ack    (ch_ack),
		.smp_data   (ch_data),
		.fifo_wr_en (smp_wr_en),
		.fifo_data  (smp_in),
		.fifo_full  (smp_full)
	);

	sync_fifo #(.WIDTH($bits(sample_t)), .DEPTH(SMP_DEPTH)) smp_fifo_i (
		.clk     (clk),
		.rst     (rst),
		.wr_en   (smp_wr_en),
		.wr_data (smp_in),
		.rd_en   (smp_rd_en),
		.rd_data (smp_head),
		.full    (smp_full),
		.empty   (smp_empty)
	);

endmodule

// File: design/sample_merger.sv
`timescale 1ns/1ps

module sample_merger import daq_pkg::*; #(
	parameter int N_CHAN = 4
) (
	input  logic              clk,
	input  logic              rst,
	input  logic [N_CHAN-1:0] smp_req,
	output logic [N_CHAN-1:0] smp_ack,
	input  sample_t           smp_data [N_CHAN],
	output logic              fifo_wr_en,
	output sample_t           fifo_data,
	input  logic              fifo_full
);

	localparam int IW = (N_CHAN > 1) ? $clog2(N_CHAN) : 1;

	logic [IW-1:0]     last;
	logic [IW-1:0]     grant;
	logic [IW-1:0]     pick;
	logic              found;
	logic              busy;
	logic [N_CHAN-1:0] ack_q;

	// Scan starts one past the last served channel
	always_comb begin
		int cand;
		found = 1'b0;
		pick  = last;
		for (int off = 1; off <= N_CHAN; off++) begin
			cand = (int'(last) + off) % N_CHAN;
			if (!found && smp_req[cand]) begin
				found = 1'b1;
				pick  = IW'(cand);
			end
		end
	end

	// A full FIFO withholds ack, which stalls the channel
	assign fifo_wr_en = !busy && found && !fifo_full;
	assign fifo_data  = smp_data[pick];

	always_ff @(posedge clk) begin
		if (rst) begin
			last  <= '0;
			grant <= '0;
			busy  <= 1'b0;
			ack_q <= '0;
		end else if (fifo_wr_en) begin
			grant       <= pick;
			last        <= pick;
			busy        <= 1'b1;
			ack_q[pick] <= 1'b1;
		end else if (busy && !smp_req[grant]) begin
			// Release phase done
			busy  <= 1'b0;
			ack_q <= '0;
		end
	end

	assign smp_ack = ack_q;

endmodule

// File: design/sample_channel.sv
`timescale 1ns/1ps

module sample_channel import daq_pkg::*; #(
	parameter int CHAN_ID = 0
) (
	input  logic    clk,
	input  logic    rst,
	chan_cmd_if.channel cmd,
	output logic    smp_req,
	input  logic    smp_ack,
	output sample_t smp_data
);

	localparam logic [CHAN_ID_BITS-1:0] CHAN_TAG = CHAN_ID_BITS'(CHAN_ID);

	typedef enum logic [1:0] {
		st_ready,
		st_offer,
		st_release
	} state_t;

	state_t state;
	value_t base;
	value_t step;
	word_t  remaining;
	logic   ack_q;
	logic   accept;

	// New commands only between runs
	assign accept = (state == st_ready) && (remaining == '0) && cmd.req && !ack_q;

	always_ff @(posedge clk) begin
		if (rst) begin
			state     <= st_ready;
			base      <= '0;
			step      <= '0;
			remaining <= '0;
			ack_q     <= 1'b0;
		end else begin
			if (accept) begin
				ack_q <= 1'b1;
				case (cmd.opcode)
					OP_SET_BASE: base      <= cmd.operand[11:0];
					OP_SET_STEP: step      <= cmd.operand[11:0];
					OP_EMIT:     remaining <= cmd.operand;
					default:     ;
				endcase
			end else if (ack_q && !cmd.req) begin
				ack_q <= 1'b0;
			end

			case (state)
				st_ready: begin
					if (remaining != '0) begin
						state <= st_offer;
					end
				end
				st_offer: begin
					// Advance on ack so a stalled sample is neither lost nor repeated
					if (smp_ack) begin
						base      <= base + step;
						remaining <= remaining - 1'b1;
						state     <= st_release;
					end
				end
				st_release: begin
					if (!smp_ack) begin
						state <= st_ready;
					end
				end
				default: begin
					state <= st_ready;
				end
			endcase
		end
	end

	assign cmd.ack  = ack_q;
	assign smp_req  = (state == st_offer);
	assign smp_data = {CHAN_TAG, base};

endmodule

// File: design/cmd_dispatcher.sv
`timescale 1ns/1ps

module cmd_dispatcher import daq_pkg::*; #(
	parameter int N_CHAN = 4
) (
	input  logic       clk,
	input  logic       rst,
	input  cmd_t       cmd_data,
	input  logic       cmd_empty,
	output logic       cmd_rd_en,
	chan_cmd_if.dispatcher chan [N_CHAN],
	output logic [7:0] bad_cmd_count
);

	typedef enum logic [1:0] {
		st_idle,
		st_check,
		st_req_high,
		st_wait_release
	} state_t;

	state_t           state;
	cmd_t             cmd_q;
	chan_id_t         chan_q;
	logic             req_on;
	logic [N_CHAN-1:0] ack_vec;
	logic             ack;

	assign chan_q    = cmd_q[55:48];
	assign req_on    = (state == st_req_high);
	assign cmd_rd_en = (state == st_idle) && !cmd_empty;

	// Only the addressed channel sees req
	for (genvar i = 0; i < N_CHAN; i++) begin : g_chan
		assign chan[i].req     = req_on && (chan_q == chan_id_t'(i));
		assign chan[i].opcode  = opcode_t'(cmd_q[63:56]);
		assign chan[i].operand = cmd_q[15:0];
		assign ack_vec[i]      = chan[i].ack && (chan_q == chan_id_t'(i));
	end

	assign ack = |ack_vec;

	always_ff @(posedge clk) begin
		if (rst) begin
			state         <= st_idle;
			bad_cmd_count <= '0;
		end else begin
			case (state)
				st_idle: begin
					if (!cmd_empty) begin
						state <= st_check;
					end
				end
				st_check: begin
					if (chan_q >= chan_id_t'(N_CHAN)) begin
						// Saturating count of commands for missing channels
						if (bad_cmd_count != 8'hff) begin
							bad_cmd_count <= bad_cmd_count + 1'b1;
						end
						state <= st_idle;
					end else begin
						state <= st_req_high;
					end
				end
				st_req_high: begin
					if (ack) begin
						state <= st_wait_release;
					end
				end
				st_wait_release: begin
					if (!ack) begin
						state <= st_idle;
					end
				end
				default: begin
					state <= st_idle;
				end
			endcase
		end
	end

	// Popped command, held while the handshake runs
	always_ff @(posedge clk) begin
		if (cmd_rd_en) begin
			cmd_q <= cmd_data;
		end
	end

endmodule

// File: ebi/ebi.sv
`timescale 1ns/1ps

module ebi import daq_pkg::*; (
	input  logic      clk,
	input  logic      rst,
	// External bus
	input  word_t     data_in,
	output word_t     data_out,
	input  ebi_addr_t addr,
	input  logic      rd,
	input  logic      wr,
	input  logic      cs,
	// Command FIFO side
	output cmd_t      cmd_data,
	output logic      cmd_wr_en,
	input  logic      cmd_full,
	input  logic      cmd_empty,
	// Sample FIFO side
	input  sample_t   smp_data,
	output logic      smp_rd_en,
	input  logic      smp_empty,
	input  logic      smp_full,
	input  logic [7:0] bad_cmd_count
);

	typedef enum logic [1:0] {
		st_idle,
		st_fetch,
		st_fifo_load,
		st_trans_over
	} state_t;

	state_t      state;
	state_t      next_state;
	logic        capture;
	logic        cmd_addr;
	logic [1:0]  slot;
	word_t       cmd_word [4];
	logic        smp_rd_now;
	logic        smp_rd_q;
	word_t       status;

	assign cmd_addr = (addr >= ADDR_CMD_W1) && (addr <= ADDR_CMD_W4);
	assign slot     = 2'(addr - ADDR_CMD_W1);

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= st_idle;
		end else begin
			state <= next_state;
		end
	end

	always_comb begin
		next_state = state;
		capture    = 1'b0;
		cmd_wr_en  = 1'b0;
		case (state)
			st_idle: begin
				next_state = st_fetch;
			end
			st_fetch: begin
				if (cs && wr && cmd_addr) begin
					capture = 1'b1;
					// Last word completes the command
					if (addr == ADDR_CMD_W4) begin
						next_state = st_fifo_load;
					end
				end
			end
			st_fifo_load: begin
				cmd_wr_en  = 1'b1;
				next_state = st_trans_over;
			end
			st_trans_over: begin
				// Hold off until the bus strobes are released
				if (!wr && !rd) begin
					next_state = st_fetch;
				end
			end
			default: begin
				next_state = st_idle;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (capture) begin
			cmd_word[slot] <= data_in;
		end
	end

	assign cmd_data = {cmd_word[0], cmd_word[1], cmd_word[2], cmd_word[3]};

	// Pop once when a sample read ends
	assign smp_rd_now = cs && rd && (addr == ADDR_SAMPLE);

	always_ff @(posedge clk) begin
		if (rst) begin
			smp_rd_q <= 1'b0;
		end else begin
			smp_rd_q <= smp_rd_now;
		end
	end

	assign smp_rd_en = smp_rd_q && !smp_rd_now && !smp_empty;

	always_comb begin
		status                       = '0;
		status[STAT_CMD_FULL]        = cmd_full;
		status[STAT_CMD_EMPTY]       = cmd_empty;
		status[STAT_SMP_EMPTY]       = smp_empty;
		status[STAT_SMP_FULL]        = smp_full;
		status[STAT_BAD_LSB +: 8]    = bad_cmd_count;
	end

	// Read mux
	always_comb begin
		case (addr)
			ADDR_STATUS: data_out = status;
			ADDR_SAMPLE: data_out = smp_empty ? '0 : smp_data;
			default:     data_out = '0;
		endcase
	end

endmodule

// File: design/sync_fifo.sv
`timescale 1ns/1ps

module sync_fifo #(
	parameter int WIDTH = 16,
	parameter int DEPTH = 16
) (
	input  logic             clk,
	input  logic             rst,
	input  logic             wr_en,
	input  logic [WIDTH-1:0] wr_data,
	input  logic             rd_en,
	output logic [WIDTH-1:0] rd_data,
	output logic             full,
	output logic             empty
);

	localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

	logic [WIDTH-1:0] mem [DEPTH];
	logic [AW-1:0]    wr_ptr;
	logic [AW-1:0]    rd_ptr;
	logic [AW:0]      count;
	logic [AW:0]      count_next;
	logic             do_wr;
	logic             do_rd;

	// Writes when full and reads when empty are dropped
	assign do_wr = wr_en && !full;
	assign do_rd = rd_en && !empty;

	always_comb begin
		case ({do_wr, do_rd})
			2'b10:   count_next = count + 1'b1;
			2'b01:   count_next = count - 1'b1;
			default: count_next = count;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
			full   <= 1'b0;
			empty  <= 1'b1;
		end else begin
			if (do_wr) begin
				wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (do_rd) begin
				rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end
			count <= count_next;
			full  <= (count_next == (AW+1)'(DEPTH));
			empty <= (count_next == '0);
		end
	end

	always_ff @(posedge clk) begin
		if (do_wr) begin
			mem[wr_ptr] <= wr_data;
		end
	end

	// Head is visible without a read strobe
	assign rd_data = mem[rd_ptr];

endmodule

// File: common/chan_cmd_if.sv
`timescale 1ns/1ps

// One decoded command, dispatcher to channel, four-phase req/ack
interface chan_cmd_if import daq_pkg::*; ();

	logic    req;
	logic    ack;
	opcode_t opcode;
	// Low 16 bits of the command operand
	word_t   operand;

	modport dispatcher (
		output req,
		output opcode,
		output operand,
		input  ack
	);

	modport channel (
		input  req,
		input  opcode,
		input  operand,
		output ack
	);

endinterface

// File: common/daq_pkg.sv
package daq_pkg;

	// External bus widths
	typedef logic [15:0] word_t;
	typedef logic [18:0] ebi_addr_t;

	// Word 1 sits in the top 16 bits: opcode byte, then channel byte
	typedef logic [63:0] cmd_t;
	typedef logic [7:0]  chan_id_t;

	typedef enum logic [7:0] {
		OP_SET_BASE = 8'h01,
		OP_SET_STEP = 8'h02,
		OP_EMIT     = 8'h03
	} opcode_t;

	// Sample word is channel id over a 12-bit ramp value
	typedef logic [15:0] sample_t;
	typedef logic [11:0] value_t;

	// Caps the channel count at 16
	localparam int CHAN_ID_BITS = 4;

	// EBI address map
	localparam ebi_addr_t ADDR_STATUS = 19'd0;
	localparam ebi_addr_t ADDR_CMD_W1 = 19'd1;
	localparam ebi_addr_t ADDR_CMD_W2 = 19'd2;
	localparam ebi_addr_t ADDR_CMD_W3 = 19'd3;
	localparam ebi_addr_t ADDR_CMD_W4 = 19'd4;
	localparam ebi_addr_t ADDR_SAMPLE = 19'd5;

	// Status word bit positions
	localparam int STAT_CMD_FULL  = 0;
	localparam int STAT_CMD_EMPTY = 1;
	localparam int STAT_SMP_EMPTY = 2;
	localparam int STAT_SMP_FULL  = 3;
	localparam int STAT_BAD_LSB   = 4;

endpackage
